// File: common/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

//////////////////////
// datapath widths
//////////////////////

// address and instruction width
`define XLEN         32
// one memory block, one cache line
`define BLOCK_BITS   64
// memory response and reply tags
`define MEM_TAG_BITS 4

//////////////////////
// icache geometry
//////////////////////

`define ICACHE_LINES 32
`define INDEX_BITS   5
`define OFFSET_BITS  3
// tag is whatever is left above index and offset, 24 bits
`define CTAG_BITS    (`XLEN - `INDEX_BITS - `OFFSET_BITS)

//////////////////////
// fetch constants
//////////////////////

`define RESET_PC     32'h0000_0000
// addi x0, x0, 0
`define NOP_INST     32'h0000_0013

`endif

// File: common/mem_bus_pkg.sv
package mem_bus_pkg;

	//////////////////////
	// memory bus encoding
	//////////////////////

	// command driven on proc2mem_command
	// store kept so the encoding matches the bus, fetch never issues it
	typedef enum logic [1:0] {
		bus_none  = 2'h0,
		bus_load  = 2'h1,
		bus_store = 2'h2
	} bus_command_e;

endpackage

// File: common/fetch_pkg.sv
package fetch_pkg;

	//////////////////////
	// icache refill FSM
	//////////////////////

	// miss_idle     no refill outstanding, watching for a miss
	// miss_request  load on the bus, waiting for a nonzero response
	// miss_wait     request accepted, waiting for the matching reply tag
	typedef enum logic [1:0] {
		miss_idle    = 2'h0,
		miss_request = 2'h1,
		miss_wait    = 2'h2
	} miss_state_e;

endpackage

// File: verilog/fetch_pc.sv
`timescale 1ns/1ps

`include "fetch_defs.svh"

module fetch_pc (
	input  logic             clock,
	input  logic             reset,
	input  logic             stall,
	input  logic             redirect,
	input  logic [`XLEN-1:0] redirect_pc,
	input  logic             hit,
	output logic [`XLEN-1:0] fetch_pc_addr
);

	logic [`XLEN-1:0] pc;

	//////////////////////
	// program counter
	//////////////////////

	// redirect beats stall, stall beats advance
	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= `RESET_PC;
		end else if (redirect) begin
			pc <= redirect_pc;
		end else if (hit && !stall) begin
			// next sequential instruction
			pc <= pc + `XLEN'd4;
		end
	end

	// on a miss the PC sits still until the line is filled
	assign fetch_pc_addr = pc;

	// redirect targets come from outside, so alignment is checked here
	assert property (@(posedge clock) disable iff (reset)
		fetch_pc_addr[1:0] == 2'b00)
		else $error("fetch PC not word aligned");

endmodule

// File: icache/icache_array.sv
`timescale 1ns/1ps

`include "fetch_defs.svh"

module icache_array (
	input  logic                      clock,
	input  logic                      reset,
	input  logic [`XLEN-1:0]          fetch_pc_addr,
	input  logic                      fill_en,
	input  logic [`XLEN-1:0]          fill_addr,
	input  logic [`BLOCK_BITS-1:0]    fill_data,
	input  fetch_pkg::miss_state_e    miss_state,
	output logic                      hit,
	output logic [`XLEN-1:0]          hit_inst
);

	//////////////////////
	// line storage
	//////////////////////

	// valid bits are control state, tags and data are payload
	logic [`ICACHE_LINES-1:0] valid;
	logic [`CTAG_BITS-1:0]    tag_mem  [`ICACHE_LINES];
	logic [`BLOCK_BITS-1:0]   data_mem [`ICACHE_LINES];

	// split of the fetch address
	logic [`INDEX_BITS-1:0]   rd_index;
	logic [`CTAG_BITS-1:0]    rd_tag;
	logic [`BLOCK_BITS-1:0]   rd_line;

	// split of the refill address
	logic [`INDEX_BITS-1:0]   fill_index;
	logic [`CTAG_BITS-1:0]    fill_tag;

	assign rd_index   = fetch_pc_addr[`OFFSET_BITS +: `INDEX_BITS];
	assign rd_tag     = fetch_pc_addr[`XLEN-1 -: `CTAG_BITS];
	assign fill_index = fill_addr[`OFFSET_BITS +: `INDEX_BITS];
	assign fill_tag   = fill_addr[`XLEN-1 -: `CTAG_BITS];

	//////////////////////
	// lookup
	//////////////////////

	// combinational read, same cycle as the PC
	assign rd_line  = data_mem[rd_index];
	assign hit      = valid[rd_index] && (tag_mem[rd_index] == rd_tag);
	// bit 2 picks the word: low half for 0, high half for 1
	assign hit_inst = fetch_pc_addr[2] ? rd_line[`BLOCK_BITS-1:`XLEN] : rd_line[`XLEN-1:0];

	//////////////////////
	// refill write
	//////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
		end else if (fill_en) begin
			valid[fill_index] <= 1'b1;
		end
	end

	// a later fill to the same index just overwrites the line
	always_ff @(posedge clock) begin
		if (fill_en) begin
			tag_mem[fill_index]  <= fill_tag;
			data_mem[fill_index] <= fill_data;
		end
	end

	// the FSM only writes once it has an accepted, matching reply
	assert property (@(posedge clock) disable iff (reset)
		fill_en |-> (miss_state == fetch_pkg::miss_wait))
		else $error("icache fill outside miss_wait");

endmodule

// File: icache/icache_miss_fsm.sv
`timescale 1ns/1ps

`include "fetch_defs.svh"

module icache_miss_fsm (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         hit,
	input  logic [`XLEN-1:0]             fetch_pc_addr,
	input  logic [`MEM_TAG_BITS-1:0]     mem2proc_response,
	input  logic [`MEM_TAG_BITS-1:0]     mem2proc_tag,
	input  logic [`BLOCK_BITS-1:0]       mem2proc_data,
	output mem_bus_pkg::bus_command_e    proc2mem_command,
	output logic [`XLEN-1:0]             proc2mem_addr,
	output logic                         fill_en,
	output logic [`XLEN-1:0]             fill_addr,
	output logic [`BLOCK_BITS-1:0]       fill_data,
	output fetch_pkg::miss_state_e       miss_state
);

	fetch_pkg::miss_state_e     state;
	fetch_pkg::miss_state_e     next_state;

	// block address of the line being refilled
	logic [`XLEN-1:0]           req_addr;
	// tag the memory handed back when it took the load
	logic [`MEM_TAG_BITS-1:0]   req_tag;
	logic                       reply_match;

	//////////////////////
	// next state
	//////////////////////

	// kept tag is never zero once in miss_wait
	assign reply_match = (state == fetch_pkg::miss_wait) && (mem2proc_tag == req_tag);

	always_comb begin
		next_state = state;
		case (state)
			fetch_pkg::miss_idle:    if (!hit) next_state = fetch_pkg::miss_request;
			fetch_pkg::miss_request: if (mem2proc_response != '0) next_state = fetch_pkg::miss_wait;
			fetch_pkg::miss_wait:    if (reply_match) next_state = fetch_pkg::miss_idle;
			default:                 next_state = fetch_pkg::miss_idle;
		endcase
	end

	// redirect is not looked at here, an in-flight refill always completes
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fetch_pkg::miss_idle;
		end else begin
			state <= next_state;
		end
	end

	//////////////////////
	// request latches
	//////////////////////

	always_ff @(posedge clock) begin
		// snapshot the missing block, low offset bits dropped
		if (state == fetch_pkg::miss_idle && !hit) begin
			req_addr <= {fetch_pc_addr[`XLEN-1:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};
		end
		// accepting edge
		if (state == fetch_pkg::miss_request && mem2proc_response != '0) begin
			req_tag <= mem2proc_response;
		end
	end

	//////////////////////
	// bus and fill side
	//////////////////////

	assign proc2mem_command = (state == fetch_pkg::miss_request) ? mem_bus_pkg::bus_load
	                                                              : mem_bus_pkg::bus_none;
	assign proc2mem_addr    = req_addr;
	assign fill_en          = reply_match;
	assign fill_addr        = req_addr;
	assign fill_data        = mem2proc_data;
	assign miss_state       = state;

	// an unaccepted request must hold its address
	assert property (@(posedge clock) disable iff (reset)
		(state == fetch_pkg::miss_request && mem2proc_response == '0)
			|=> $stable(proc2mem_addr))
		else $error("request address moved before acceptance");

	// once the load is taken the bus goes quiet, one refill at a time
	assert property (@(posedge clock) disable iff (reset)
		(proc2mem_command == mem_bus_pkg::bus_load && mem2proc_response != '0)
			|=> (proc2mem_command == mem_bus_pkg::bus_none))
		else $error("bus command still driven after acceptance");

endmodule

// File: verilog/if_id_reg.sv
`timescale 1ns/1ps

`include "fetch_defs.svh"

module if_id_reg (
	input  logic             clock,
	input  logic             reset,
	input  logic             stall,
	input  logic             redirect,
	input  logic             hit,
	input  logic [`XLEN-1:0] hit_inst,
	input  logic [`XLEN-1:0] fetch_pc_addr,
	output logic [`XLEN-1:0] if_id_inst,
	output logic [`XLEN-1:0] if_id_pc,
	output logic             if_id_valid
);

	logic clear;

	//////////////////////
	// IF/ID register
	//////////////////////

	// a miss while not stalled leaves a bubble
	assign clear = reset || redirect || (!hit && !stall);

	always_ff @(posedge clock) begin
		if (clear) begin
			// bubble: NOP with valid low
			if_id_inst  <= `NOP_INST;
			if_id_pc    <= '0;
			if_id_valid <= 1'b0;
		end else if (!stall) begin
			// hit is high here, so the word is good
			if_id_inst  <= hit_inst;
			if_id_pc    <= fetch_pc_addr;
			if_id_valid <= 1'b1;
		end
		// stall: everything held
	end

endmodule

// File: verilog/fetch_top.sv
`timescale 1ns/1ps

`include "fetch_defs.svh"

module fetch_top (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         stall,
	input  logic                         redirect,
	input  logic [`XLEN-1:0]             redirect_pc,
	input  logic [`MEM_TAG_BITS-1:0]     mem2proc_response,
	input  logic [`MEM_TAG_BITS-1:0]     mem2proc_tag,
	input  logic [`BLOCK_BITS-1:0]       mem2proc_data,
	output mem_bus_pkg::bus_command_e    proc2mem_command,
	output logic [`XLEN-1:0]             proc2mem_addr,
	output logic [`XLEN-1:0]             if_id_inst,
	output logic [`XLEN-1:0]             if_id_pc,
	output logic                         if_id_valid
);

	// PC to cache and IF/ID
	logic [`XLEN-1:0]         fetch_pc_addr;
	// cache lookup result
	logic                     hit;
	logic [`XLEN-1:0]         hit_inst;
	// refill path, FSM to array
	logic                     fill_en;
	logic [`XLEN-1:0]         fill_addr;
	logic [`BLOCK_BITS-1:0]   fill_data;
	fetch_pkg::miss_state_e   miss_state;

	//////////////////////
	// fetch PC
	//////////////////////

	fetch_pc i_fetch_pc (
		.clock         (clock),
		.reset         (reset),
		.stall         (stall),
		.redirect      (redirect),
		.redirect_pc   (redirect_pc),
		.hit           (hit),
		.fetch_pc_addr (fetch_pc_addr)
	);

	//////////////////////
	// icache
	//////////////////////

	icache_array i_icache_array (
		.clock         (clock),
		.reset         (reset),
		.fetch_pc_addr (fetch_pc_addr),
		.fill_en       (fill_en),
		.fill_addr     (fill_addr),
		.fill_data     (fill_data),
		.miss_state    (miss_state),
		.hit           (hit),
		.hit_inst      (hit_inst)
	);

	// only the I-side talks to memory
	icache_miss_fsm i_icache_miss_fsm (
		.clock             (clock),
		.reset             (reset),
		.hit               (hit),
		.fetch_pc_addr     (fetch_pc_addr),
		.mem2proc_response (mem2proc_response),
		.mem2proc_tag      (mem2proc_tag),
		.mem2proc_data     (mem2proc_data),
		.proc2mem_command  (proc2mem_command),
		.proc2mem_addr     (proc2mem_addr),
		.fill_en           (fill_en),
		.fill_addr         (fill_addr),
		.fill_data         (fill_data),
		.miss_state        (miss_state)
	);

	//////////////////////
	// IF/ID
	//////////////////////

	if_id_reg i_if_id_reg (
		.clock         (clock),
		.reset         (reset),
		.stall         (stall),
		.redirect      (redirect),
		.hit           (hit),
		.hit_inst      (hit_inst),
		.fetch_pc_addr (fetch_pc_addr),
		.if_id_inst    (if_id_inst),
		.if_id_pc      (if_id_pc),
		.if_id_valid   (if_id_valid)
	);

endmodule

// File: tb/fetch_tb.sv
`timescale 1ns/1ps

`include "fetch_defs.svh"

module fetch_tb;

	localparam int NUM_TESTS = 8;

	// one row per test
	typedef struct packed {
		logic [31:0] addr;
		int          count;
		int          busy;
		int          latency;
		bit          stray;
		int          stall_code;
		int          requests;
	} test_row_t;

	test_row_t rows [NUM_TESTS];

	logic                         clock = 1'b0;
	logic                         reset;
	logic                         stall;
	logic                         redirect;
	logic [`XLEN-1:0]             redirect_pc;
	logic [`MEM_TAG_BITS-1:0]     mem2proc_response;
	logic [`MEM_TAG_BITS-1:0]     mem2proc_tag;
	logic [`BLOCK_BITS-1:0]       mem2proc_data;
	mem_bus_pkg::bus_command_e    proc2mem_command;
	logic [`XLEN-1:0]             proc2mem_addr;
	logic [`XLEN-1:0]             if_id_inst;
	logic [`XLEN-1:0]             if_id_pc;
	logic                         if_id_valid;

	// memory model knobs, set per test
	int          cur_busy;
	int          cur_latency;
	bit          cur_stray;
	// memory model status, updated on the rising edge only
	int          accepted;
	int          replies;
	logic        model_idle;
	int          model_errors;

	int          errors;
	int          failed;
	int          cycles = 0;
	int          cycle_limit;
	logic [31:0] lfsr_state = 32'hbf5628a4;

	always #2 clock = ~clock;

	fetch_top i_fetch_top (
		.clock             (clock),
		.reset             (reset),
		.stall             (stall),
		.redirect          (redirect),
		.redirect_pc       (redirect_pc),
		.mem2proc_response (mem2proc_response),
		.mem2proc_tag      (mem2proc_tag),
		.mem2proc_data     (mem2proc_data),
		.proc2mem_command  (proc2mem_command),
		.proc2mem_addr     (proc2mem_addr),
		.if_id_inst        (if_id_inst),
		.if_id_pc          (if_id_pc),
		.if_id_valid       (if_id_valid)
	);

	//////////////////////
	// helpers
	//////////////////////

	// fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic int take_bits(input int count);
		int   value;
		logic feedback;
		value = 0;
		for (int i = 0; i < count; i++) begin
			feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], feedback};
			value      = (value << 1) | int'(feedback);
		end
		return value;
	endfunction

	// word at A is A xor 5a5a0000, high word sits at block + 4
	function automatic logic [63:0] block_data(input logic [31:0] block);
		return {(block + 32'd4) ^ 32'h5a5a_0000, block ^ 32'h5a5a_0000};
	endfunction

	// addr, count, busy, latency, stray, stall code, requests
	task automatic load_tests();
		// from reset, two lines
		rows[0] = '{`RESET_PC,     4, 0, 1, 1'b0, 0, 2};
		// eight new lines
		rows[1] = '{32'h0000_0018, 16, 0, 1, 1'b0, 1, 8};
		// all cached
		rows[2] = '{32'h0000_0008, 20, 0, 1, 1'b0, 1, 0};
		// 256 bytes away, same index as 0x08
		rows[3] = '{32'h0000_0108, 2, 0, 1, 1'b0, 0, 1};
		rows[4] = '{32'h0000_0008, 2, 0, 1, 1'b0, 0, 1};
		// busy memory
		rows[5] = '{32'h0000_0060, 2, 3, 1, 1'b0, 0, 1};
		// stray replies
		rows[6] = '{32'h0000_0080, 4, 0, 3, 1'b1, 0, 2};
		// heavy stall
		rows[7] = '{32'h0000_00a0, 8, 1, 2, 1'b0, 2, 4};
	endtask

	//////////////////////
	// memory model
	//////////////////////

	initial begin
		logic [`MEM_TAG_BITS-1:0] resp;
		logic [`MEM_TAG_BITS-1:0] tag;
		logic [`BLOCK_BITS-1:0]   data;
		logic [`MEM_TAG_BITS-1:0] next_tag;
		logic [`MEM_TAG_BITS-1:0] held_tag;
		logic [`XLEN-1:0]         held_addr;
		logic                     outstanding;
		logic                     took;
		logic                     gave;
		int                       busy_seen;
		int                       latency_left;

		mem2proc_response = '0;
		mem2proc_tag      = '0;
		mem2proc_data     = '0;
		next_tag          = 4'd1;
		held_tag          = '0;
		held_addr         = '0;
		outstanding       = 1'b0;
		busy_seen         = 0;
		latency_left      = 0;
		accepted          = 0;
		replies           = 0;
		model_idle        = 1'b1;
		model_errors      = 0;
		forever begin
			// look at the bus mid cycle, answer on the next rising edge
			@(negedge clock);
			resp = '0;
			tag  = '0;
			data = '0;
			took = 1'b0;
			gave = 1'b0;
			if (outstanding) begin
				latency_left = latency_left - 1;
				if (latency_left <= 0) begin
					tag         = held_tag;
					data        = block_data(held_addr);
					outstanding = 1'b0;
					gave        = 1'b1;
				end else if (cur_stray && latency_left == 1) begin
					// other tag, junk data
					tag  = (held_tag == 4'd15) ? 4'd1 : held_tag + 4'd1;
					data = ~block_data(held_addr);
				end
			end else if (proc2mem_command == mem_bus_pkg::bus_load) begin
				if (busy_seen == 0) begin
					held_addr = proc2mem_addr;
					if (proc2mem_addr[2:0] != 3'b000) begin
						$display("load request at %h is not block aligned", proc2mem_addr);
						model_errors++;
					end
				end else if (proc2mem_addr !== held_addr) begin
					$display("ERROR proc2mem_addr: got %h expected %h", proc2mem_addr, held_addr);
					model_errors++;
				end
				if (busy_seen < cur_busy) begin
					busy_seen++;
				end else begin
					resp         = next_tag;
					held_tag     = next_tag;
					// tags run 1..15, zero means busy
					next_tag     = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
					busy_seen    = 0;
					latency_left = cur_latency;
					outstanding  = 1'b1;
					took         = 1'b1;
				end
			end
			@(posedge clock);
			mem2proc_response <= resp;
			mem2proc_tag      <= tag;
			mem2proc_data     <= data;
			if (took) accepted = accepted + 1;
			if (gave) replies = replies + 1;
			model_idle = !outstanding && busy_seen == 0;
		end
	end

	//////////////////////
	// timeout
	//////////////////////

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display(">>> FAIL");
			$finish;
		end
	end

	//////////////////////
	// stimulus and checks
	//////////////////////

	initial begin
		int          t;
		int          seen;
		int          quiet;
		int          start_accepted;
		int          start_replies;
		int          made;
		int          errors_before;
		logic        stall_at_edge;
		logic [31:0] exp_pc;
		logic [31:0] held_inst;
		logic [31:0] held_pc;
		logic        held_valid;

		reset       = 1'b1;
		stall       = 1'b0;
		redirect    = 1'b0;
		redirect_pc = '0;
		cur_busy    = 0;
		cur_latency = 1;
		cur_stray   = 1'b0;
		errors      = 0;
		failed      = 0;
		load_tests();
		cycle_limit = 100;
		for (t = 0; t < NUM_TESTS; t++) begin
			cycle_limit = cycle_limit
				+ rows[t].count * (rows[t].latency + 3 + rows[t].busy + 8);
		end

		repeat (4) @(posedge clock);
		reset <= 1'b0;
		// last edge still had reset high
		@(negedge clock);
		if (proc2mem_command != mem_bus_pkg::bus_none) begin
			$display("ERROR proc2mem_command: got %h expected %h",
				proc2mem_command, mem_bus_pkg::bus_none);
			errors++;
		end
		if (if_id_valid !== 1'b0) begin
			$display("ERROR if_id_valid: got %h expected %h", if_id_valid, 1'b0);
			errors++;
		end

		for (t = 0; t < NUM_TESTS; t++) begin
			// counters only read mid cycle
			errors_before  = errors + model_errors;
			start_accepted = accepted;
			start_replies  = replies;
			exp_pc         = rows[t].addr;
			seen           = 0;
			@(posedge clock);
			cur_busy    = rows[t].busy;
			cur_latency = rows[t].latency + take_bits(2);
			cur_stray   = rows[t].stray;
			// test 0 runs from the reset PC
			if (t != 0) begin
				redirect    <= 1'b1;
				redirect_pc <= rows[t].addr;
			end
			stall      <= 1'b0;
			held_inst  = if_id_inst;
			held_pc    = if_id_pc;
			held_valid = if_id_valid;
			while (seen < rows[t].count) begin
				@(posedge clock);
				// what the DUT samples at this edge
				stall_at_edge = stall;
				redirect <= 1'b0;
				stall    <= (take_bits(2) < rows[t].stall_code);
				@(negedge clock);
				if (stall_at_edge) begin
					if (if_id_inst !== held_inst) begin
						$display("ERROR if_id_inst: got %h expected %h", if_id_inst, held_inst);
						errors++;
					end
					if (if_id_pc !== held_pc) begin
						$display("ERROR if_id_pc: got %h expected %h", if_id_pc, held_pc);
						errors++;
					end
					if (if_id_valid !== held_valid) begin
						$display("ERROR if_id_valid: got %h expected %h", if_id_valid, held_valid);
						errors++;
					end
				end else if (if_id_valid) begin
					// first line of every test that refills starts on a miss
					if (rows[t].requests != 0 && replies == start_replies) begin
						$display("instruction at %h showed up before its refill", if_id_pc);
						errors++;
					end
					if (if_id_pc !== exp_pc) begin
						$display("ERROR if_id_pc: got %h expected %h", if_id_pc, exp_pc);
						errors++;
					end
					if (if_id_inst !== (exp_pc ^ 32'h5a5a_0000)) begin
						$display("ERROR if_id_inst: got %h expected %h",
							if_id_inst, exp_pc ^ 32'h5a5a_0000);
						errors++;
					end
					exp_pc = exp_pc + 32'd4;
					seen++;
				end
				held_inst  = if_id_inst;
				held_pc    = if_id_pc;
				held_valid = if_id_valid;
			end
			// the next line's refill cannot be accepted yet
			made = accepted - start_accepted;
			if (made != rows[t].requests) begin
				$display("ERROR request count: got %h expected %h", made, rows[t].requests);
				errors++;
			end

			// park the PC and let any refill already started drain
			@(posedge clock);
			stall <= 1'b1;
			quiet = 0;
			while (quiet < 4) begin
				@(negedge clock);
				if (model_idle && proc2mem_command == mem_bus_pkg::bus_none) begin
					quiet++;
				end else begin
					quiet = 0;
				end
			end
			if (errors + model_errors != errors_before) failed++;
			$display("test %0d at %h: %0d instructions, %0d requests, %s", t, rows[t].addr,
				seen, made, (errors + model_errors == errors_before) ? "ok" : "failed");
		end

		$display("tests %0d, failed %0d, errors %0d", NUM_TESTS, failed, errors + model_errors);
		if (errors + model_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: flist.f
+incdir+common
common/mem_bus_pkg.sv
common/fetch_pkg.sv
verilog/fetch_pc.sv
icache/icache_array.sv
icache/icache_miss_fsm.sv
verilog/if_id_reg.sv
verilog/fetch_top.sv
tb/fetch_tb.sv

// File: Makefile
.PHONY: sim clean

# pass or fail comes from the log, the simulator exit code is not used
sim:
	verilator --binary --timing --assert -f flist.f --top-module fetch_tb \
		-Mdir obj_dir -o fetch_sim
	./obj_dir/fetch_sim | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
